/* hdl/cipherFilterPkg.sv */
// Shared widths, mode and select codes, round keys and constants
// Flit and select types, plus the seed builder used by both pad generators
`default_nettype none

package cipherFilterPkg;

	// ------------------------------
	// Stream geometry
	// ------------------------------
	localparam int FlitWidth = 64;
	// Clear IV field in the low header bits
	localparam int IVWidth = 16;
	// Flit 0 of each bucket is the header
	localparam int BktFlits = 4;
	localparam int PathBuckets = 4;
	localparam int BucketIdxWidth = 2;
	localparam int ChunkIdxWidth = 2;

	// ------------------------------
	// Access modes and pad selects
	// ------------------------------
	localparam int ModeWidth = 2;
	localparam logic [ModeWidth-1:0] ModeReadOnly = 2'd0;
	localparam logic [ModeWidth-1:0] ModeFull = 2'd1;
	localparam logic [ModeWidth-1:0] ModeHeader = 2'd2;
	// Code 3 reserved, data passes through

	localparam int SelWidth = 2;
	localparam logic [SelWidth-1:0] SelNone = 2'd0;
	localparam logic [SelWidth-1:0] SelHeader = 2'd1;
	localparam logic [SelWidth-1:0] SelPayload = 2'd2;

	// ------------------------------
	// Toy mixer parameters
	// ------------------------------
	localparam logic [FlitWidth-1:0] RoundKey0 = 64'h3c6e_f372_a54f_f53a;
	localparam logic [FlitWidth-1:0] RoundKey1 = 64'h510e_527f_9b05_688c;
	localparam logic [FlitWidth-1:0] RoundConst0 = 64'h9e37_79b9_7f4a_7c15;
	localparam logic [FlitWidth-1:0] RoundConst1 = 64'hbb67_ae85_84ca_a73b;
	localparam int RoundRot = 7;
	// One register per round
	localparam int PadLatency = 2;

	typedef logic [FlitWidth-1:0] flitT;
	typedef logic [SelWidth-1:0] selT;

	// Seed layout: IV on top, bucket and chunk at the bottom, zeros between
	function automatic flitT makeSeed(
		input logic [IVWidth-1:0] iv,
		input logic [BucketIdxWidth-1:0] bucket,
		input logic [ChunkIdxWidth-1:0] chunk
	);
		return {iv, {(FlitWidth-IVWidth-BucketIdxWidth-ChunkIdxWidth){1'b0}}, bucket, chunk};
	endfunction

endpackage

`default_nettype wire

/* hdl/padRound.sv */
// One registered round of the keyed toy mixer
`timescale 1ns/1ps
`default_nettype none

module padRound
	import cipherFilterPkg::*;
(
	input wire Clock,
	input wire reset,
	input wire flitT In,
	input wire flitT RoundKey,
	input wire flitT RoundConst,
	output flitT Out
);

	flitT keyed;
	flitT rotated;
	flitT mixed;

	// ------------------------------
	// Round function
	// ------------------------------

	// Key whitening
	assign keyed = In ^ RoundKey;

	// Rotate left by a fixed amount
	assign rotated = {keyed[FlitWidth-RoundRot-1:0], keyed[FlitWidth-1:FlitWidth-RoundRot]};

	// Add round constant, wraps mod 2^64
	assign mixed = rotated + RoundConst;

	// Pipeline register, one cycle per round
	always_ff @(posedge Clock) begin
		if (reset) begin
			Out <= '0;
		end else begin
			Out <= mixed;
		end
	end

endmodule

`default_nettype wire

/* hdl/flitTracker.sv */
// Path position counters, latched access mode and per-flit pad select
`timescale 1ns/1ps
`default_nettype none

module flitTracker
	import cipherFilterPkg::*;
(
	input wire Clock,
	input wire reset,
	input wire Start,
	input wire [ModeWidth-1:0] Mode,
	input wire [BucketIdxWidth-1:0] TargetBucket,
	input wire DataInValid,
	output logic FlitIsHeader,
	output logic [BucketIdxWidth-1:0] BucketIdx,
	output logic [ChunkIdxWidth-1:0] ChunkIdx,
	output selT Sel
);

	logic [ChunkIdxWidth-1:0] chunkCount;
	logic [BucketIdxWidth-1:0] bucketCount;
	logic [ModeWidth-1:0] modeReg;
	logic [BucketIdxWidth-1:0] targetReg;
	logic [ModeWidth-1:0] curMode;
	logic [BucketIdxWidth-1:0] curTarget;

	// ------------------------------
	// Current flit position
	// ------------------------------

	// Start takes effect in its own cycle
	assign curMode = Start ? Mode : modeReg;
	assign curTarget = Start ? TargetBucket : targetReg;
	assign BucketIdx = Start ? '0 : bucketCount;
	assign ChunkIdx = Start ? '0 : chunkCount;
	assign FlitIsHeader = (ChunkIdx == '0);

	always_ff @(posedge Clock) begin
		if (reset) begin
			chunkCount <= '0;
			bucketCount <= '0;
			modeReg <= ModeFull;
			targetReg <= '0;
		end else begin
			if (Start) begin
				modeReg <= Mode;
				targetReg <= TargetBucket;
			end
			// Advance from the current position, Start included
			if (DataInValid) begin
				if (ChunkIdx == ChunkIdxWidth'(BktFlits-1)) begin
					chunkCount <= '0;
					// Wrap after the last bucket of the path
					if (BucketIdx == BucketIdxWidth'(PathBuckets-1))
						bucketCount <= '0;
					else
						bucketCount <= BucketIdx + 1'b1;
				end else begin
					chunkCount <= ChunkIdx + 1'b1;
					bucketCount <= BucketIdx;
				end
			end else if (Start) begin
				chunkCount <= '0;
				bucketCount <= '0;
			end
		end
	end

	// ------------------------------
	// Pad select per mode
	// ------------------------------
	always_comb begin
		Sel = SelNone;
		case (curMode)
			ModeReadOnly: begin
				if (FlitIsHeader)
					Sel = SelHeader;
				else if (BucketIdx == curTarget)
					Sel = SelPayload;
			end
			ModeFull: Sel = FlitIsHeader ? SelHeader : SelPayload;
			ModeHeader: Sel = FlitIsHeader ? SelHeader : SelNone;
			// Reserved code leaves Sel at none
			default: Sel = SelNone;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/headerPadGen.sv */
// Header pad generator, seeded from the IV carried in the flit itself
`timescale 1ns/1ps
`default_nettype none

module headerPadGen
	import cipherFilterPkg::*;
(
	input wire Clock,
	input wire reset,
	input wire flitT DataIn,
	input wire [BucketIdxWidth-1:0] BucketIdx,
	input wire [ChunkIdxWidth-1:0] ChunkIdx,
	output flitT HeaderPad
);

	flitT seed;
	flitT round0;
	flitT round1;

	// ------------------------------
	// Seed and two rounds
	// ------------------------------

	// IV sits in clear in the low header bits
	assign seed = makeSeed(DataIn[IVWidth-1:0], BucketIdx, ChunkIdx);

	padRound round0_i (
		.Clock(Clock),
		.reset(reset),
		.In(seed),
		.RoundKey(RoundKey0),
		.RoundConst(RoundConst0),
		.Out(round0)
	);

	padRound round1_i (
		.Clock(Clock),
		.reset(reset),
		.In(round0),
		.RoundKey(RoundKey1),
		.RoundConst(RoundConst1),
		.Out(round1)
	);

	// Zero pad over the IV field, so the IV is never ciphered
	assign HeaderPad = {round1[FlitWidth-1:IVWidth], {IVWidth{1'b0}}};

endmodule

`default_nettype wire

/* hdl/payloadPadGen.sv */
// Payload pad generator
// Holds the IV of the current bucket, taken from its header flit
`timescale 1ns/1ps
`default_nettype none

module payloadPadGen
	import cipherFilterPkg::*;
(
	input wire Clock,
	input wire reset,
	input wire flitT DataIn,
	input wire DataInValid,
	input wire FlitIsHeader,
	input wire [BucketIdxWidth-1:0] BucketIdx,
	input wire [ChunkIdxWidth-1:0] ChunkIdx,
	output flitT PayloadPad
);

	logic [IVWidth-1:0] bucketIV;
	flitT seed;
	flitT round0;

	// ------------------------------
	// Bucket IV latch
	// ------------------------------

	// Header always precedes the payload of its bucket
	always_ff @(posedge Clock) begin
		if (DataInValid && FlitIsHeader)
			bucketIV <= DataIn[IVWidth-1:0];
	end

	// Pad for header flits is never selected
	assign seed = makeSeed(bucketIV, BucketIdx, ChunkIdx);

	// ------------------------------
	// Two rounds
	// ------------------------------
	padRound round0_i (
		.Clock(Clock),
		.reset(reset),
		.In(seed),
		.RoundKey(RoundKey0),
		.RoundConst(RoundConst0),
		.Out(round0)
	);

	// Full-width pad, no field kept in clear
	padRound round1_i (
		.Clock(Clock),
		.reset(reset),
		.In(round0),
		.RoundKey(RoundKey1),
		.RoundConst(RoundConst1),
		.Out(PayloadPad)
	);

endmodule

`default_nettype wire

/* hdl/alignDelay.sv */
// Shift register delay line, PadLatency deep, for any payload type
`timescale 1ns/1ps
`default_nettype none

module alignDelay
	import cipherFilterPkg::*;
#(
	parameter type T = logic
) (
	input wire Clock,
	input wire reset,
	input wire T In,
	output T Out
);

	T stages [PadLatency];

	always_ff @(posedge Clock) begin
		if (reset) begin
			for (int i = 0; i < PadLatency; i++)
				stages[i] <= '0;
		end else begin
			stages[0] <= In;
			for (int i = 1; i < PadLatency; i++)
				stages[i] <= stages[i-1];
		end
	end

	// Oldest entry
	assign Out = stages[PadLatency-1];

endmodule

`default_nettype wire

/* hdl/streamMixer.sv */
// Aligns input data with the pads, selects a pad and XORs it in
// Output data and valid are registered
`timescale 1ns/1ps
`default_nettype none

module streamMixer
	import cipherFilterPkg::*;
(
	input wire Clock,
	input wire reset,
	input wire flitT DataIn,
	input wire DataInValid,
	input wire selT Sel,
	input wire flitT HeaderPad,
	input wire flitT PayloadPad,
	output flitT DataOut,
	output logic DataOutValid
);

	flitT dataAligned;
	selT selAligned;
	logic [PadLatency-1:0] validPipe;
	flitT pad;

	// ------------------------------
	// Alignment with pad pipelines
	// ------------------------------
	alignDelay #(
		.T(flitT)
	) dataDelay_i (
		.Clock(Clock),
		.reset(reset),
		.In(DataIn),
		.Out(dataAligned)
	);

	alignDelay #(
		.T(selT)
	) selDelay_i (
		.Clock(Clock),
		.reset(reset),
		.In(Sel),
		.Out(selAligned)
	);

	// Valid strobe in its own shift register
	always_ff @(posedge Clock) begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[PadLatency-2:0], DataInValid};
	end

	// ------------------------------
	// Pad select and XOR
	// ------------------------------
	always_comb begin
		case (selAligned)
			SelHeader: pad = HeaderPad;
			SelPayload: pad = PayloadPad;
			// None, and any unused code
			default: pad = '0;
		endcase
	end

	always_ff @(posedge Clock) begin
		DataOut <= dataAligned ^ pad;
	end

	always_ff @(posedge Clock) begin
		if (reset)
			DataOutValid <= 1'b0;
		else
			DataOutValid <= validPipe[PadLatency-1];
	end

endmodule

`default_nettype wire

/* hdl/rewCipherFilter.sv */
// Top of the stream cipher filter
// Tracker, header and payload pad generators, output mixer
`timescale 1ns/1ps
`default_nettype none

module rewCipherFilter
	import cipherFilterPkg::*;
(
	input wire Clock,
	input wire reset,
	input wire Start,
	input wire [ModeWidth-1:0] Mode,
	input wire [BucketIdxWidth-1:0] TargetBucket,
	input wire flitT DataIn,
	input wire DataInValid,
	output flitT DataOut,
	output logic DataOutValid
);

	logic flitIsHeader;
	logic [BucketIdxWidth-1:0] bucketIdx;
	logic [ChunkIdxWidth-1:0] chunkIdx;
	selT sel;
	flitT headerPad;
	flitT payloadPad;

	// ------------------------------
	// Position and pad select
	// ------------------------------
	flitTracker tracker_i (
		.Clock(Clock),
		.reset(reset),
		.Start(Start),
		.Mode(Mode),
		.TargetBucket(TargetBucket),
		.DataInValid(DataInValid),
		.FlitIsHeader(flitIsHeader),
		.BucketIdx(bucketIdx),
		.ChunkIdx(chunkIdx),
		.Sel(sel)
	);

	// ------------------------------
	// Pad generators, side by side
	// ------------------------------
	headerPadGen headerGen_i (
		.Clock(Clock),
		.reset(reset),
		.DataIn(DataIn),
		.BucketIdx(bucketIdx),
		.ChunkIdx(chunkIdx),
		.HeaderPad(headerPad)
	);

	payloadPadGen payloadGen_i (
		.Clock(Clock),
		.reset(reset),
		.DataIn(DataIn),
		.DataInValid(DataInValid),
		.FlitIsHeader(flitIsHeader),
		.BucketIdx(bucketIdx),
		.ChunkIdx(chunkIdx),
		.PayloadPad(payloadPad)
	);

	// Output stage, 3 cycles after the input flit
	streamMixer mixer_i (
		.Clock(Clock),
		.reset(reset),
		.DataIn(DataIn),
		.DataInValid(DataInValid),
		.Sel(sel),
		.HeaderPad(headerPad),
		.PayloadPad(payloadPad),
		.DataOut(DataOut),
		.DataOutValid(DataOutValid)
	);

endmodule

`default_nettype wire

/* dv/rewCipherFilterTb.sv */
// Testbench for the stream cipher filter
// Reference model, scoreboard with latency check, watchdog
`timescale 1ns/1ps
`default_nettype none

module rewCipherFilterTb
	import cipherFilterPkg::*;
();

	localparam int PathLen = BktFlits * PathBuckets;
	// Short access ending inside bucket 1
	localparam int PartLen = 7;
	localparam int MaxGap = 3;
	localparam int Latency = 3;
	// Test 1 to 6 in order
	localparam int StimFlits = 3 * PathLen + 4 * PathLen + (PartLen + 2 * PathLen) + PathLen
		+ (PartLen + PathLen);
	localparam int GapCycles = MaxGap * (PartLen + 2 * PathLen);
	// Ten drains and two resets
	localparam int IdleCycles = 12 * (Latency + 3) + 10;
	localparam int CycleLimit = StimFlits + GapCycles + IdleCycles + 20;

	logic Clock = 1'b0;
	logic reset;
	logic Start;
	logic [ModeWidth-1:0] Mode;
	logic [BucketIdxWidth-1:0] TargetBucket;
	flitT DataIn;
	logic DataInValid;
	flitT DataOut;
	logic DataOutValid;

	// Reference position and mode
	logic [ModeWidth-1:0] refMode;
	int refTarget;
	int refBucket;
	int refChunk;
	logic [IVWidth-1:0] refIV;

	// Scoreboard
	flitT expQ[$];
	int cycQ[$];
	flitT sent[$];
	flitT captured[$];
	flitT plain[$];
	flitT cipher[$];
	int cycle = 0;
	int seed;
	string testName = "reset";

	rewCipherFilter dut_i (
		.Clock(Clock),
		.reset(reset),
		.Start(Start),
		.Mode(Mode),
		.TargetBucket(TargetBucket),
		.DataIn(DataIn),
		.DataInValid(DataInValid),
		.DataOut(DataOut),
		.DataOutValid(DataOutValid)
	);

	initial begin
		forever #50 Clock = ~Clock;
	end

	// ------------------------------
	// Reference model
	// ------------------------------

	// Key XOR, rotate left, add constant
	function automatic flitT mixRound(input flitT x, input flitT key, input flitT rc);
		flitT t;
		t = x ^ key;
		return ((t << RoundRot) | (t >> (FlitWidth - RoundRot))) + rc;
	endfunction

	function automatic flitT padFor(input logic [IVWidth-1:0] iv, input int bucket,
		input int chunk);
		flitT s;
		s = '0;
		s[FlitWidth-1 -: IVWidth] = iv;
		s[3:2] = bucket[1:0];
		s[1:0] = chunk[1:0];
		return mixRound(mixRound(s, RoundKey0, RoundConst0), RoundKey1, RoundConst1);
	endfunction

	function automatic flitT expectedFlit(input flitT data, input logic [ModeWidth-1:0] mode,
		input int target, input int bucket, input int chunk, input logic [IVWidth-1:0] iv);
		flitT pad;
		pad = '0;
		if (chunk == 0) begin
			// Reserved mode leaves headers alone
			if (mode == ModeReadOnly || mode == ModeFull || mode == ModeHeader) begin
				pad = padFor(data[IVWidth-1:0], bucket, 0);
				pad[IVWidth-1:0] = '0;
			end
		end else if (mode == ModeFull || (mode == ModeReadOnly && bucket == target)) begin
			pad = padFor(iv, bucket, chunk);
		end
		return data ^ pad;
	endfunction

	function automatic flitT randFlit();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic resetRef();
		refMode = ModeFull;
		refTarget = 0;
		refBucket = 0;
		refChunk = 0;
	endtask

	// ------------------------------
	// Error reporting
	// ------------------------------
	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic reportMismatch(input string what, input flitT expVal, input flitT actVal);
		stopOnError($sformatf("[FAIL] %s: expected %h actual %h", what, expVal, actVal));
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------

	// One flit with its expected output and input cycle queued
	task automatic sendFlit(input flitT data, input logic startAcc,
		input logic [ModeWidth-1:0] mode, input int target);
		@(posedge Clock);
		Start <= startAcc;
		Mode <= mode;
		TargetBucket <= target[BucketIdxWidth-1:0];
		DataIn <= data;
		DataInValid <= 1'b1;
		if (startAcc) begin
			refMode = mode;
			refTarget = target;
			refBucket = 0;
			refChunk = 0;
		end
		if (refChunk == 0)
			refIV = data[IVWidth-1:0];
		expQ.push_back(expectedFlit(data, refMode, refTarget, refBucket, refChunk, refIV));
		// Input seen at the next negedge
		cycQ.push_back(cycle + 1);
		sent.push_back(data);
		if (refChunk == BktFlits - 1) begin
			refChunk = 0;
			refBucket = (refBucket + 1) % PathBuckets;
		end else begin
			refChunk++;
		end
	endtask

	// Junk data while valid is low
	task automatic idleCycle();
		@(posedge Clock);
		Start <= 1'b0;
		DataInValid <= 1'b0;
		DataIn <= randFlit();
	endtask

	task automatic sendAccess(input int count, input logic withStart,
		input logic [ModeWidth-1:0] mode, input int target, input int maxGap);
		int gap;
		for (int i = 0; i < count; i++) begin
			sendFlit(randFlit(), withStart && i == 0, mode, target);
			gap = (maxGap > 0) ? ($unsigned($random(seed)) % (maxGap + 1)) : 0;
			repeat (gap) idleCycle();
		end
	endtask

	task automatic drain();
		idleCycle();
		while (expQ.size() != 0)
			idleCycle();
	endtask

	task automatic beginTest(input string name);
		testName = name;
		sent.delete();
		captured.delete();
	endtask

	// Reset with flits in flight
	task automatic applyReset();
		@(posedge Clock);
		reset <= 1'b1;
		Start <= 1'b0;
		DataInValid <= 1'b0;
		@(posedge Clock);
		// Outputs from here on are lost
		expQ.delete();
		cycQ.delete();
		@(posedge Clock);
		reset <= 1'b0;
		resetRef();
		@(negedge Clock);
		assert (DataOutValid === 1'b0)
			else stopOnError("DataOutValid was high in the cycle after reset");
	endtask

	// ------------------------------
	// Compare and watchdog
	// ------------------------------
	always @(negedge Clock) begin : compare
		flitT expVal;
		int inCyc;
		cycle = cycle + 1;
		if (cycle > CycleLimit)
			stopOnError($sformatf("Run did not finish within %0d cycles", CycleLimit));
		if (DataOutValid === 1'b1) begin
			assert (expQ.size() != 0)
				else stopOnError({"DataOutValid high with no flit outstanding in ", testName});
			if (expQ.size() != 0) begin
				expVal = expQ.pop_front();
				inCyc = cycQ.pop_front();
				assert (cycle - inCyc == Latency)
					else stopOnError($sformatf("[FAIL] %s latency: expected %0d actual %0d",
						testName, Latency, cycle - inCyc));
				assert (DataOut === expVal)
					else reportMismatch(testName, expVal, DataOut);
				captured.push_back(DataOut);
			end
		end else if (expQ.size() != 0) begin
			assert (cycle - cycQ[0] < Latency)
				else stopOnError({"A flit got no output in time in ", testName});
		end
	end

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		seed = 32'hed21d47d;
		reset = 1'b1;
		Start = 1'b0;
		Mode = ModeFull;
		TargetBucket = '0;
		DataIn = '0;
		DataInValid = 1'b0;
		resetRef();
		repeat (2) @(posedge Clock);
		reset <= 1'b0;

		// Full path and then its ciphertext back in
		beginTest("full path");
		sendAccess(PathLen, 1'b1, ModeFull, 0, 0);
		drain();
		plain = sent;
		cipher = captured;
		for (int i = 0; i < PathLen; i++) begin
			assert (i % BktFlits != 0 || cipher[i][IVWidth-1:0] == plain[i][IVWidth-1:0])
				else reportMismatch("full path header IV", plain[i], cipher[i]);
			assert (cipher[i][FlitWidth-1:IVWidth] != plain[i][FlitWidth-1:IVWidth])
				else stopOnError($sformatf("Flit %0d of the full path was left in clear", i));
		end
		beginTest("full round trip");
		for (int i = 0; i < PathLen; i++)
			sendFlit(cipher[i], i == 0, ModeFull, 0);
		drain();
		for (int i = 0; i < PathLen; i++)
			assert (captured[i] === plain[i])
				else reportMismatch("full round trip", plain[i], captured[i]);

		beginTest("header only");
		sendAccess(PathLen, 1'b1, ModeHeader, 0, 0);
		drain();

		for (int t = 0; t < PathBuckets; t++) begin
			beginTest($sformatf("read only target %0d", t));
			sendAccess(PathLen, 1'b1, ModeReadOnly, t, 0);
			drain();
		end

		// Back to back accesses with the first one cut short
		beginTest("gaps and restarts");
		sendAccess(PartLen, 1'b1, ModeReadOnly, 1, MaxGap);
		sendAccess(PathLen, 1'b1, ModeFull, 0, MaxGap);
		sendAccess(PathLen, 1'b1, ModeReadOnly, 3, MaxGap);
		drain();

		beginTest("reserved mode");
		sendAccess(PathLen, 1'b1, 2'd3, 0, 0);
		drain();
		for (int i = 0; i < PathLen; i++)
			assert (captured[i] === sent[i])
				else reportMismatch("reserved mode", sent[i], captured[i]);

		// No Start after reset, so Mode input is ignored
		beginTest("reset mid path");
		sendAccess(PartLen, 1'b1, ModeReadOnly, 2, 0);
		applyReset();
		sendAccess(PathLen, 1'b0, ModeHeader, 0, 0);
		drain();

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hdl/cipherFilterPkg.sv
hdl/padRound.sv
hdl/flitTracker.sv
hdl/headerPadGen.sv
hdl/payloadPadGen.sv
hdl/alignDelay.sv
hdl/streamMixer.sv
hdl/rewCipherFilter.sv
dv/rewCipherFilterTb.sv

/* Bender.yml */
package:
  name: rew_cipher_filter

sources:
  # Package first, then leaf modules, then the top level
  - hdl/cipherFilterPkg.sv
  - hdl/padRound.sv
  - hdl/flitTracker.sv
  - hdl/headerPadGen.sv
  - hdl/payloadPadGen.sv
  - hdl/alignDelay.sv
  - hdl/streamMixer.sv
  - hdl/rewCipherFilter.sv
  - target: simulation
    files:
      - dv/rewCipherFilterTb.sv
